// ==== hw/dac_tx_defines.svh ====
// Widths, register offsets and source codes shared by the DAC transmit datapath.
// Include in any file that needs these constants.
`ifndef DAC_TX_DEFINES_SVH
`define DAC_TX_DEFINES_SVH

// data widths
`define DAC_WIDTH      12
`define DMA_WIDTH      16
`define SEL_WIDTH      4

// channel source codes
`define SEL_TONE       4'd0
`define SEL_PATTERN    4'd1
`define SEL_DMA        4'd2
`define SEL_ZERO       4'd3
`define SEL_RAMP_UP    4'd4
`define SEL_RAMP_DOWN  4'd5
`define SEL_PN23       4'd6

// pn23 samples before the source falls to zero
`define PN_LENGTH      1024

// register byte offsets
`define REG_CTRL       8'h00
`define REG_I_BASE     8'h40
`define REG_Q_BASE     8'h80

// per-channel offsets from the channel base
`define REG_SEL_OFS    8'h00
`define REG_TONE1_OFS  8'h04
`define REG_TONE2_OFS  8'h08
`define REG_SCALE_OFS  8'h0c
`define REG_PAT_OFS    8'h10
`define REG_COEF_OFS   8'h14
`define REG_CH_WORDS   4'd6

`endif

// ==== hw/dac_cfg_pkg.sv ====
// Configuration types passed from the register map to the datapath.
// Import where channel or corrector settings are used.
`include "dac_tx_defines.svh"

package dac_cfg_pkg;

  // **************************************************
  // per-channel source settings
  // **************************************************

  typedef struct packed {
    // source select, one of the SEL_* codes
    logic [`SEL_WIDTH-1:0] sel;
    // tone phase accumulators
    logic [15:0]           tone1_init;
    logic [15:0]           tone1_incr;
    logic [15:0]           tone2_init;
    logic [15:0]           tone2_incr;
    // tone amplitude, unsigned, 1.0 is 0x8000
    logic [15:0]           tone1_scale;
    logic [15:0]           tone2_scale;
    // alternating pattern, top 12 bits reach the DAC
    logic [15:0]           pat1;
    logic [15:0]           pat2;
  } chan_cfg_t;

  // **************************************************
  // i/q corrector settings
  // **************************************************

  typedef struct packed {
    logic        enable;
    // signed coefficients, 1.0 is 0x4000
    logic [15:0] i_coeff1;
    logic [15:0] i_coeff2;
    logic [15:0] q_coeff1;
    logic [15:0] q_coeff2;
  } iqcor_cfg_t;

endpackage

// ==== hw/dac_sample_pkg.sv ====
// Sample types that flow through the transmit datapath.
`include "dac_tx_defines.svh"

package dac_sample_pkg;

  // dma word pair, one per channel
  typedef struct packed {
    logic [`DMA_WIDTH-1:0] i;
    logic [`DMA_WIDTH-1:0] q;
  } dma_sample_t;

  // one channel output
  typedef struct packed {
    logic                  valid;
    logic [`DAC_WIDTH-1:0] data;
  } chan_sample_t;

  // final words to the DAC
  typedef struct packed {
    logic                  valid;
    logic [`DAC_WIDTH-1:0] i;
    logic [`DAC_WIDTH-1:0] q;
  } tx_sample_t;

endpackage

// ==== hw/dac_regmap.sv ====
// AXI4-Lite register map for both channels and the I/Q corrector.
// Packs register fields into config structs and issues the sync pulse.
`timescale 1ns/1ps
`include "dac_tx_defines.svh"

module dac_regmap
  import dac_cfg_pkg::*;
(
  input  logic        dac_clk,
  input  logic        rst_n,
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  output chan_cfg_t   cfg_i,
  output chan_cfg_t   cfg_q,
  output iqcor_cfg_t  iq_cfg,
  output logic        sync
);

  localparam int unsigned IDX_SEL   = `REG_SEL_OFS / 4;
  localparam int unsigned IDX_TONE1 = `REG_TONE1_OFS / 4;
  localparam int unsigned IDX_TONE2 = `REG_TONE2_OFS / 4;
  localparam int unsigned IDX_SCALE = `REG_SCALE_OFS / 4;
  localparam int unsigned IDX_PAT   = `REG_PAT_OFS / 4;
  localparam int unsigned IDX_COEF  = `REG_COEF_OFS / 4;

  // index 0 is the i channel, 1 is q
  logic [5:0][31:0] ch_regs [2];
  logic             iqcor_en;
  logic             wr_accept;
  logic             rd_accept;
  logic [31:0]      rd_mux;

  function automatic logic in_bank(input logic [7:0] addr, input logic [7:0] base);
    return ((addr & 8'hc0) == base) && (addr[5:2] < `REG_CH_WORDS);
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old_v,
                                        input logic [31:0] new_v,
                                        input logic [3:0]  strb);
    logic [31:0] res;
    int          b;
    res = old_v;
    for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic chan_cfg_t pack_chan(input logic [5:0][31:0] r);
    chan_cfg_t c;
    c.sel         = r[IDX_SEL][`SEL_WIDTH-1:0];
    c.tone1_incr  = r[IDX_TONE1][15:0];
    c.tone1_init  = r[IDX_TONE1][31:16];
    c.tone2_incr  = r[IDX_TONE2][15:0];
    c.tone2_init  = r[IDX_TONE2][31:16];
    c.tone1_scale = r[IDX_SCALE][15:0];
    c.tone2_scale = r[IDX_SCALE][31:16];
    c.pat1        = r[IDX_PAT][15:0];
    c.pat2        = r[IDX_PAT][31:16];
    return c;
  endfunction

  // **************************************************
  // write channel
  // **************************************************

  // address and data must arrive together, one response outstanding
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign bresp     = 2'b00;

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      ch_regs[0] <= '0;
      ch_regs[1] <= '0;
      iqcor_en   <= 1'b0;
      sync       <= 1'b0;
      bvalid     <= 1'b0;
    end else begin
      // sync self-clears after one cycle
      sync <= 1'b0;
      if (wr_accept) begin
        bvalid <= 1'b1;
        if (awaddr == `REG_CTRL) begin
          if (wstrb[0]) begin
            sync     <= wdata[0];
            iqcor_en <= wdata[1];
          end
        end else if (in_bank(awaddr, `REG_I_BASE)) begin
          ch_regs[0][awaddr[4:2]] <= merge(ch_regs[0][awaddr[4:2]], wdata, wstrb);
        end else if (in_bank(awaddr, `REG_Q_BASE)) begin
          ch_regs[1][awaddr[4:2]] <= merge(ch_regs[1][awaddr[4:2]], wdata, wstrb);
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // **************************************************
  // read channel
  // **************************************************

  assign rd_accept = arvalid && !rvalid;
  assign arready   = rd_accept;
  assign rresp     = 2'b00;

  // unmapped addresses read zero, sync bit always reads zero
  always_comb begin
    rd_mux = '0;
    if (araddr == `REG_CTRL) begin
      rd_mux = {30'd0, iqcor_en, 1'b0};
    end else if (in_bank(araddr, `REG_I_BASE)) begin
      rd_mux = ch_regs[0][araddr[4:2]];
    end else if (in_bank(araddr, `REG_Q_BASE)) begin
      rd_mux = ch_regs[1][araddr[4:2]];
    end
  end

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (rd_accept) begin
      rdata <= rd_mux;
    end
  end

  // config out
  assign cfg_i = pack_chan(ch_regs[0]);
  assign cfg_q = pack_chan(ch_regs[1]);
  assign iq_cfg = '{enable:   iqcor_en,
                    i_coeff1: ch_regs[0][IDX_COEF][15:0],
                    i_coeff2: ch_regs[0][IDX_COEF][31:16],
                    q_coeff1: ch_regs[1][IDX_COEF][15:0],
                    q_coeff2: ch_regs[1][IDX_COEF][31:16]};

  // responses hold, with stable read data, until taken
  a_bvalid_hold: assert property (@(posedge dac_clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge dac_clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== hw/dac_tx_channel.sv ====
// One transmit channel that picks tone, pattern, DMA, zero, ramp or PN23 samples.
// Instantiated once for I and once for Q.
`timescale 1ns/1ps
`include "dac_tx_defines.svh"

module dac_tx_channel
  import dac_cfg_pkg::*, dac_sample_pkg::*;
(
  input  logic                  dac_clk,
  input  logic                  rst_n,
  input  logic                  dac_valid,
  input  logic [`DMA_WIDTH-1:0] dma_data,
  input  chan_cfg_t             cfg,
  input  logic                  sync,
  output chan_sample_t          sample,
  output logic                  dac_enable
);

  localparam int unsigned PN_CNT_W = $clog2(`PN_LENGTH) + 1;

  logic [15:0]           phase1;
  logic [15:0]           phase2;
  logic [30:0]           prod1;
  logic [30:0]           prod2;
  logic [15:0]           tone_sum;
  logic                  pat_sel;
  logic [22:0]           pn_state;
  logic [PN_CNT_W-1:0]   pn_cnt;
  logic                  pn_done;
  logic [`DAC_WIDTH-1:0] src_data;
  logic [`DAC_WIDTH-1:0] data_q;
  logic                  valid_q;

  // folds the phase into a rising then falling ramp
  function automatic logic [14:0] tri_wave(input logic [15:0] ph);
    return ph[15] ? ~ph[14:0] : ph[14:0];
  endfunction

  // **************************************************
  // tone source
  // **************************************************

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase1 <= '0;
      phase2 <= '0;
    end else if (sync) begin
      phase1 <= cfg.tone1_init;
      phase2 <= cfg.tone2_init;
    end else if (dac_valid) begin
      phase1 <= phase1 + cfg.tone1_incr;
      phase2 <= phase2 + cfg.tone2_incr;
    end
  end

  // scaled tones drop 15 fraction bits and their sum wraps at 16 bits
  assign prod1    = tri_wave(phase1) * cfg.tone1_scale;
  assign prod2    = tri_wave(phase2) * cfg.tone2_scale;
  assign tone_sum = prod1[30:15] + prod2[30:15];

  // **************************************************
  // pattern and pn23 sources
  // **************************************************

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      pat_sel <= 1'b0;
    end else if (sync) begin
      pat_sel <= 1'b0;
    end else if (dac_valid) begin
      pat_sel <= ~pat_sel;
    end
  end

  assign pn_done = (pn_cnt == PN_CNT_W'(`PN_LENGTH));

  // reseeds to all ones while another source is selected
  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      pn_state <= '1;
      pn_cnt   <= '0;
    end else if (cfg.sel != `SEL_PN23) begin
      pn_state <= '1;
      pn_cnt   <= '0;
    end else if (dac_valid && !pn_done) begin
      pn_state <= {pn_state[21:0], pn_state[22] ^ pn_state[17]};
      pn_cnt   <= pn_cnt + 1'b1;
    end
  end

  // **************************************************
  // source mux and output register
  // **************************************************

  always_comb begin
    case (cfg.sel)
      `SEL_TONE:      src_data = tone_sum[15:4];
      `SEL_PATTERN:   src_data = pat_sel ? cfg.pat2[15:4] : cfg.pat1[15:4];
      `SEL_DMA:       src_data = dma_data[`DMA_WIDTH-1 -: `DAC_WIDTH];
      `SEL_ZERO:      src_data = '0;
      `SEL_RAMP_UP:   src_data = data_q + 1'b1;
      `SEL_RAMP_DOWN: src_data = data_q - 1'b1;
      `SEL_PN23:      src_data = pn_done ? '0 : pn_state[`DAC_WIDTH-1:0];
      default:        src_data = '0;
    endcase
  end

  // output register that the ramps step from
  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= 1'b0;
      data_q     <= '0;
      dac_enable <= 1'b0;
    end else begin
      valid_q    <= dac_valid;
      dac_enable <= (cfg.sel == `SEL_DMA);
      if (dac_valid) begin
        data_q <= src_data;
      end
    end
  end

  assign sample = '{valid: valid_q, data: data_q};

  // select written through the register map must be a known source
  a_sel_range: assert property (@(posedge dac_clk) disable iff (!rst_n)
    dac_valid |-> cfg.sel <= `SEL_PN23);

endmodule

// ==== hw/dac_iqcor.sv ====
// I/Q correction: mixes both channel samples with per-output coefficients.
// Sits after the two channels and drives the final DAC words.
`timescale 1ns/1ps
`include "dac_tx_defines.svh"

module dac_iqcor
  import dac_cfg_pkg::*, dac_sample_pkg::*;
(
  input  logic         dac_clk,
  input  logic         rst_n,
  input  chan_sample_t i_in,
  input  chan_sample_t q_in,
  input  iqcor_cfg_t   cfg,
  output tx_sample_t   tx
);

  logic                  valid_q;
  logic [`DAC_WIDTH-1:0] i_q;
  logic [`DAC_WIDTH-1:0] q_q;

  // own*c1 + other*c2, coefficients are 2.14 fixed point
  function automatic logic [`DAC_WIDTH-1:0] correct(
    input logic signed [`DAC_WIDTH-1:0] own,
    input logic signed [`DAC_WIDTH-1:0] other,
    input logic signed [15:0]           c1,
    input logic signed [15:0]           c2
  );
    logic signed [27:0] p1;
    logic signed [27:0] p2;
    logic signed [28:0] acc;
    logic signed [14:0] shifted;
    p1      = own * c1;
    p2      = other * c2;
    acc     = p1 + p2;
    shifted = acc[28:14];
    // clamp to the 12-bit signed range
    if (shifted > 15'sd2047) begin
      return 12'h7ff;
    end else if (shifted < -15'sd2048) begin
      return 12'h800;
    end
    return shifted[`DAC_WIDTH-1:0];
  endfunction

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_in.valid;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (i_in.valid) begin
      if (cfg.enable) begin
        i_q <= correct(i_in.data, q_in.data, cfg.i_coeff1, cfg.i_coeff2);
        q_q <= correct(q_in.data, i_in.data, cfg.q_coeff1, cfg.q_coeff2);
      end else begin
        // bypass
        i_q <= i_in.data;
        q_q <= q_in.data;
      end
    end
  end

  assign tx = '{valid: valid_q, i: i_q, q: q_q};

  // both channels see the same strobe, so they stay aligned
  a_valid_align: assert property (@(posedge dac_clk) disable iff (!rst_n)
    i_in.valid == q_in.valid);

endmodule

// ==== hw/dac_tx_core.sv ====
// Top of the two-channel DAC transmit path.
// Joins the register map, the I and Q channels and the corrector.
`timescale 1ns/1ps

module dac_tx_core
  import dac_cfg_pkg::*, dac_sample_pkg::*;
(
  input  logic        dac_clk,
  input  logic        rst_n,
  // axi4-lite slave
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  // sample path
  input  logic        dac_valid,
  input  dma_sample_t dma,
  output tx_sample_t  tx,
  output logic        enable_i,
  output logic        enable_q
);

  chan_cfg_t    cfg_i;
  chan_cfg_t    cfg_q;
  iqcor_cfg_t   iq_cfg;
  logic         sync;
  chan_sample_t sample_i;
  chan_sample_t sample_q;

  dac_regmap i_regmap (
    .dac_clk (dac_clk), .rst_n (rst_n),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .cfg_i (cfg_i), .cfg_q (cfg_q), .iq_cfg (iq_cfg), .sync (sync)
  );

  dac_tx_channel dac_tx_channel_i (
    .dac_clk (dac_clk), .rst_n (rst_n), .dac_valid (dac_valid),
    .dma_data (dma.i), .cfg (cfg_i), .sync (sync),
    .sample (sample_i), .dac_enable (enable_i)
  );

  dac_tx_channel dac_tx_channel_q (
    .dac_clk (dac_clk), .rst_n (rst_n), .dac_valid (dac_valid),
    .dma_data (dma.q), .cfg (cfg_q), .sync (sync),
    .sample (sample_q), .dac_enable (enable_q)
  );

  dac_iqcor i_iqcor (
    .dac_clk (dac_clk), .rst_n (rst_n),
    .i_in (sample_i), .q_in (sample_q), .cfg (iq_cfg), .tx (tx)
  );

endmodule

// ==== verif/dac_tx_tb.sv ====
// Testbench for the DAC transmit core with AXI4-Lite setup, DMA stimulus and channel models.
// Concurrent assertions compare tx two cycles after each sample.
`timescale 1ns/1ps
`include "dac_tx_defines.svh"

module dac_tx_tb
  import dac_sample_pkg::*;
;

  typedef struct packed {
    logic        en_i;
    logic        en_q;
    logic [11:0] i;
    logic [11:0] q;
  } expect_t;

  logic dac_clk = 1'b0;
  logic rst_n = 1'b0;
  logic [7:0] awaddr = '0;
  logic awvalid = 1'b0;
  logic awready;
  logic [31:0] wdata = '0;
  logic [3:0] wstrb = '0;
  logic wvalid = 1'b0;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready = 1'b1;
  logic [7:0] araddr = '0;
  logic arvalid = 1'b0;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready = 1'b1;
  logic dac_valid = 1'b0;
  dma_sample_t dma = '0;
  tx_sample_t tx;
  logic enable_i;
  logic enable_q;

  // **************************************************
  // model state and bookkeeping
  // **************************************************

  logic [31:0] mreg [2][6];
  logic        m_iq_en = 1'b0;
  logic [15:0] m_ph1 [2];
  logic [15:0] m_ph2 [2];
  logic        m_pat [2];
  logic [22:0] m_pn [2];
  int          m_pn_cnt [2];
  logic [11:0] m_out [2];
  expect_t     exp_now = '0;
  expect_t     exp_d1 = '0;
  expect_t     exp_d2 = '0;
  logic [15:0] lfsr = 16'd53305;
  string       test_name = "reset";
  int          err_count = 0;
  int          errs_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  dac_tx_core dut (.*);

  always #2 dac_clk = ~dac_clk;

  always @(posedge dac_clk) begin
    exp_d1 <= exp_now;
    exp_d2 <= exp_d1;
  end

  a_tx_data: assert property (@(posedge dac_clk) disable iff (!rst_n)
    dac_valid |-> ##2 (tx.valid && tx.i == exp_d2.i && tx.q == exp_d2.q &&
                       enable_i == exp_d2.en_i && enable_q == exp_d2.en_q))
    else begin
      err_count++;
      $display("Error %s: expected i=%h q=%h en=%b%b, actual i=%h q=%h en=%b%b",
               test_name, $sampled(exp_d2.i), $sampled(exp_d2.q),
               $sampled(exp_d2.en_i), $sampled(exp_d2.en_q), $sampled(tx.i),
               $sampled(tx.q), $sampled(enable_i), $sampled(enable_q));
    end

  a_tx_gap: assert property (@(posedge dac_clk) disable iff (!rst_n)
    !dac_valid |-> ##2 !tx.valid)
    else begin
      err_count++;
      $display("%s: tx.valid set two cycles after a cycle with no sample", test_name);
    end

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic next_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], next_bit()};
    end
    return r;
  endfunction

  function automatic logic [15:0] scaled_triangle(input logic [15:0] ph,
                                                  input logic [15:0] scale);
    logic [14:0] t;
    logic [31:0] p;
    t = ph[15] ? ~ph[14:0] : ph[14:0];
    p = {17'd0, t} * {16'd0, scale};
    return p[30:15];
  endfunction

  // advances one channel by one sample and returns its new output word
  function automatic logic [11:0] step_channel(input int ch);
    logic [3:0]  sel;
    logic [15:0] sum;
    logic [11:0] out;
    sel = mreg[ch][0][3:0];
    sum = scaled_triangle(m_ph1[ch], mreg[ch][3][15:0]) +
          scaled_triangle(m_ph2[ch], mreg[ch][3][31:16]);
    case (sel)
      `SEL_TONE:      out = sum[15:4];
      `SEL_PATTERN:   out = m_pat[ch] ? mreg[ch][4][31:20] : mreg[ch][4][15:4];
      `SEL_DMA:       out = (ch == 0) ? dma.i[15:4] : dma.q[15:4];
      `SEL_RAMP_UP:   out = m_out[ch] + 12'd1;
      `SEL_RAMP_DOWN: out = m_out[ch] - 12'd1;
      `SEL_PN23:      out = (m_pn_cnt[ch] >= `PN_LENGTH) ? 12'd0 : m_pn[ch][11:0];
      default:        out = 12'd0;
    endcase
    m_ph1[ch] = m_ph1[ch] + mreg[ch][1][15:0];
    m_ph2[ch] = m_ph2[ch] + mreg[ch][2][15:0];
    m_pat[ch] = ~m_pat[ch];
    if (sel == `SEL_PN23 && m_pn_cnt[ch] < `PN_LENGTH) begin
      m_pn[ch] = {m_pn[ch][21:0], m_pn[ch][22] ^ m_pn[ch][17]};
      m_pn_cnt[ch]++;
    end
    m_out[ch] = out;
    return out;
  endfunction

  // signed own*c1 + other*c2 floored by 14 bits and clamped to 12 bits
  function automatic logic [11:0] corrected(input logic [11:0] own, input logic [11:0] other,
                                            input logic [15:0] c1, input logic [15:0] c2);
    int a;
    int b;
    int s;
    a = $signed(own);
    b = $signed(other);
    s = (a * $signed(c1) + b * $signed(c2)) >>> 14;
    if (s > 2047) s = 2047;
    if (s < -2048) s = -2048;
    return s[11:0];
  endfunction

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic model_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    if (addr == `REG_CTRL && strb[0]) begin
      m_iq_en = data[1];
      if (data[0]) begin
        for (int ch = 0; ch < 2; ch++) begin
          m_ph1[ch] = mreg[ch][1][31:16];
          m_ph2[ch] = mreg[ch][2][31:16];
          m_pat[ch] = 1'b0;
        end
      end
    end
    for (int ch = 0; ch < 2; ch++) begin
      if (addr[7:6] == ch + 1 && addr[5:2] < 6 && addr[1:0] == 0) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) mreg[ch][addr[4:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
      // pn23 reseeds while another source is selected
      if (mreg[ch][0][3:0] != `SEL_PN23) begin
        m_pn[ch] = '1;
        m_pn_cnt[ch] = 0;
      end
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb = 4'hf);
    int t;
    @(negedge dac_clk);
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    t = 0;
    @(posedge dac_clk);
    while (!(awready && wready)) begin
      if (t == 100) abort("write address and data never accepted");
      @(posedge dac_clk);
      t++;
    end
    @(negedge dac_clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    t = 0;
    while (!bvalid) begin
      if (t == 100) abort("write response never arrived");
      @(negedge dac_clk);
      t++;
    end
    assert (bresp == 2'b00) else begin
      err_count++;
      $display("Error %s: addr %h expected bresp 0, actual bresp %0d", test_name, addr, bresp);
    end
    @(negedge dac_clk);
    model_write(addr, data, strb);
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [31:0] expected);
    int t;
    logic [31:0] got;
    logic [1:0]  resp;
    @(negedge dac_clk);
    araddr = addr;
    arvalid = 1'b1;
    t = 0;
    @(posedge dac_clk);
    while (!arready) begin
      if (t == 100) abort("read address never accepted");
      @(posedge dac_clk);
      t++;
    end
    @(negedge dac_clk);
    arvalid = 1'b0;
    t = 0;
    while (!rvalid) begin
      if (t == 100) abort("read response never arrived");
      @(negedge dac_clk);
      t++;
    end
    got = rdata;
    resp = rresp;
    @(negedge dac_clk);
    assert (got == expected && resp == 2'b00) else begin
      err_count++;
      $display("Error %s: addr %h expected %h resp 0, actual %h resp %0d",
               test_name, addr, expected, got, resp);
    end
  endtask

  // drives n cycles of random dma words with optional gaps in dac_valid
  task automatic send_samples(input int n, input bit gapped);
    logic [11:0] oi;
    logic [11:0] oq;
    for (int k = 0; k < n; k++) begin
      @(negedge dac_clk);
      dac_valid = gapped ? next_bit() : 1'b1;
      dma = rand_bits(32);
      if (dac_valid) begin
        oi = step_channel(0);
        oq = step_channel(1);
        exp_now.en_i = (mreg[0][0][3:0] == `SEL_DMA);
        exp_now.en_q = (mreg[1][0][3:0] == `SEL_DMA);
        if (m_iq_en) begin
          exp_now.i = corrected(oi, oq, mreg[0][5][15:0], mreg[0][5][31:16]);
          exp_now.q = corrected(oq, oi, mreg[1][5][15:0], mreg[1][5][31:16]);
        end else begin
          exp_now.i = oi;
          exp_now.q = oq;
        end
      end
    end
    @(negedge dac_clk);
    dac_valid = 1'b0;
    // drain the two-stage pipeline
    repeat (3) @(negedge dac_clk);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errs_at_start = err_count;
  endtask

  task automatic end_test();
    int n;
    n = err_count - errs_at_start;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("test %-12s %s (%0d errors)", test_name, (n == 0) ? "ok" : "failed", n);
  endtask

  // **************************************************
  // stimulus
  // **************************************************

  initial begin
    for (int ch = 0; ch < 2; ch++) begin
      for (int r = 0; r < 6; r++) mreg[ch][r] = '0;
      m_ph1[ch] = '0;
      m_ph2[ch] = '0;
      m_pat[ch] = 1'b0;
      m_pn[ch] = '1;
      m_pn_cnt[ch] = 0;
      m_out[ch] = '0;
    end
    repeat (10) @(posedge dac_clk);
    @(negedge dac_clk);
    rst_n = 1'b1;

    start_test("regmap");
    check_read(`REG_CTRL, 32'd0);
    for (int r = 0; r < 6; r++) begin
      check_read(`REG_I_BASE + 8'(4 * r), 32'd0);
      check_read(`REG_Q_BASE + 8'(4 * r), 32'd0);
    end
    axi_write(8'h44, 32'h1234_5678);
    check_read(8'h44, 32'h1234_5678);
    axi_write(8'h44, 32'haabb_ccdd, 4'b0101);
    check_read(8'h44, 32'h12bb_56dd);
    axi_write(8'h60, 32'hffff_ffff);
    check_read(8'h60, 32'd0);
    check_read(8'hc0, 32'd0);
    axi_write(`REG_CTRL, 32'h3);
    check_read(`REG_CTRL, 32'h2);
    axi_write(`REG_CTRL, 32'h0);
    end_test();

    start_test("dma");
    axi_write(`REG_I_BASE, `SEL_DMA);
    axi_write(`REG_Q_BASE, `SEL_DMA);
    send_samples(60, 1'b1);
    end_test();

    start_test("zero_ramp");
    axi_write(`REG_I_BASE, `SEL_RAMP_UP);
    axi_write(`REG_Q_BASE, `SEL_RAMP_DOWN);
    send_samples(40, 1'b1);
    axi_write(`REG_I_BASE, `SEL_ZERO);
    axi_write(`REG_Q_BASE, `SEL_ZERO);
    send_samples(10, 1'b0);
    end_test();

    start_test("pattern_tone");
    axi_write(`REG_I_BASE + 8'h10, 32'habc0_1230);
    axi_write(`REG_I_BASE, `SEL_PATTERN);
    axi_write(`REG_Q_BASE + 8'h04, 32'h1000_0345);
    axi_write(`REG_Q_BASE + 8'h08, 32'h8000_0a01);
    axi_write(`REG_Q_BASE + 8'h0c, 32'h4000_7fff);
    axi_write(`REG_Q_BASE, `SEL_TONE);
    axi_write(`REG_CTRL, 32'h1);
    send_samples(80, 1'b1);
    end_test();

    start_test("pn23");
    axi_write(`REG_I_BASE, `SEL_PN23);
    axi_write(`REG_Q_BASE, `SEL_PN23);
    send_samples(1040, 1'b0);
    axi_write(`REG_I_BASE, `SEL_ZERO);
    send_samples(5, 1'b0);
    axi_write(`REG_I_BASE, `SEL_PN23);
    send_samples(20, 1'b1);
    end_test();

    start_test("iqcor");
    axi_write(`REG_I_BASE, `SEL_DMA);
    axi_write(`REG_Q_BASE, `SEL_DMA);
    axi_write(`REG_I_BASE + 8'h14, 32'hf000_5000);
    axi_write(`REG_Q_BASE + 8'h14, 32'h2000_6000);
    axi_write(`REG_CTRL, 32'h2);
    send_samples(80, 1'b1);
    axi_write(`REG_CTRL, 32'h0);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hw
hw/dac_cfg_pkg.sv
hw/dac_sample_pkg.sv
hw/dac_regmap.sv
hw/dac_tx_channel.sv
hw/dac_iqcor.sv
hw/dac_tx_core.sv
verif/dac_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the DAC transmit testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module dac_tx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vdac_tx_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
